// ==== isa_pkg.sv ====
package isa_pkg;

    ////////////////////////////////////////
    // basic word types

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [4:0]  shamt_t;

    typedef enum logic [1:0] {
        SHIFT_LSL = 2'b00,
        SHIFT_LSR = 2'b01,
        SHIFT_ASR = 2'b10,
        SHIFT_ROR = 2'b11
    } shift_t;

    ////////////////////////////////////////
    // op field and data-processing commands

    localparam logic [1:0] OP_DATA = 2'b00;
    localparam logic [1:0] OP_MEM  = 2'b01;

    localparam logic [3:0] CMD_AND = 4'b0000;
    localparam logic [3:0] CMD_EOR = 4'b0001;
    localparam logic [3:0] CMD_SUB = 4'b0010;
    localparam logic [3:0] CMD_ADD = 4'b0100;
    localparam logic [3:0] CMD_ORR = 4'b1100;
    localparam logic [3:0] CMD_MOV = 4'b1101;

    ////////////////////////////////////////
    // field positions inside the instruction word

    localparam int OP_MSB    = 27;
    localparam int OP_LSB    = 26;
    localparam int IMM_BIT   = 25;
    localparam int CMD_MSB   = 24;
    localparam int CMD_LSB   = 21;
    // U and L bits only mean something for LDR/STR
    localparam int UP_BIT    = 23;
    localparam int LOAD_BIT  = 20;
    localparam int RN_LSB    = 16;
    localparam int RD_LSB    = 12;
    localparam int RM_LSB    = 0;
    localparam int SHAMT_LSB = 7;
    localparam int SH_LSB    = 5;

    localparam int IMM8_W  = 8;
    localparam int IMM12_W = 12;

    localparam reg_idx_t PC_REG = 4'd15;

endpackage

// ==== pipe_pkg.sv ====
package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_ORR    = 3'd3,
        ALU_EOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_t;

    // operand source for execute
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_t;

    localparam int          NUM_GP_REGS   = 15;
    localparam logic [31:0] PC_STEP       = 32'd4;
    localparam logic [31:0] PC_R15_OFFSET = 32'd8;
    localparam logic [31:0] RESET_PC      = 32'h0000_0000;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file import isa_pkg::*; import pipe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t ra1,
    input  reg_idx_t ra2,
    input  reg_idx_t wa,
    input  logic     we,
    input  word_t    wd,
    input  word_t    r15,
    output word_t    rd1,
    output word_t    rd2
);

    word_t regs [NUM_GP_REGS];

    // r15 comes from the pc, otherwise a same-cycle write wins over the array
    function automatic word_t read_port(reg_idx_t ra);
        if (ra == PC_REG)
            return r15;
        else if (we && (ra == wa))
            return wd;
        else
            return regs[ra];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_GP_REGS; i++)
                regs[i] <= '0;
        end else if (we && (wa != PC_REG)) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = read_port(ra1);
    assign rd2 = read_port(ra2);

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import isa_pkg::*; import pipe_pkg::*; (
    input  word_t    instr,
    output reg_idx_t ra1,
    output reg_idx_t ra2,
    output reg_idx_t wa,
    output logic     reg_write,
    output logic     mem_write,
    output logic     mem_to_reg,
    output logic     alu_src,
    output alu_op_t  alu_op,
    output word_t    ext_imm,
    output shift_t   shift_type,
    output shamt_t   shamt
);

    logic [1:0] op;
    logic [3:0] cmd;
    reg_idx_t   rn;
    reg_idx_t   rd;
    reg_idx_t   rm;

    assign op  = instr[OP_MSB:OP_LSB];
    assign cmd = instr[CMD_MSB:CMD_LSB];
    assign rn  = instr[RN_LSB +: $bits(reg_idx_t)];
    assign rd  = instr[RD_LSB +: $bits(reg_idx_t)];
    assign rm  = instr[RM_LSB +: $bits(reg_idx_t)];

    // shift fields pass straight through, execute ignores them for immediates
    assign shift_type = shift_t'(instr[SH_LSB +: $bits(shift_t)]);
    assign shamt      = instr[SHAMT_LSB +: $bits(shamt_t)];

    always_comb begin
        ra1        = rn;
        ra2        = rm;
        wa         = rd;
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        alu_src    = 1'b0;
        alu_op     = ALU_ADD;
        ext_imm    = word_t'(instr[IMM8_W-1:0]);

        case (op)
            OP_DATA: begin
                alu_src   = instr[IMM_BIT];
                reg_write = 1'b1;
                case (cmd)
                    CMD_AND: alu_op = ALU_AND;
                    CMD_EOR: alu_op = ALU_EOR;
                    CMD_SUB: alu_op = ALU_SUB;
                    CMD_ADD: alu_op = ALU_ADD;
                    CMD_ORR: alu_op = ALU_ORR;
                    CMD_MOV: alu_op = ALU_PASS_B;
                    // other commands are not implemented, treat as no-op
                    default: reg_write = 1'b0;
                endcase
            end
            OP_MEM: begin
                alu_src = 1'b1;
                ext_imm = word_t'(instr[IMM12_W-1:0]);
                if (instr[UP_BIT])
                    alu_op = ALU_ADD;
                else
                    alu_op = ALU_SUB;
                if (instr[LOAD_BIT]) begin
                    reg_write  = 1'b1;
                    mem_to_reg = 1'b1;
                end else begin
                    // store data comes from rd
                    ra2       = rd;
                    mem_write = 1'b1;
                end
            end
            default: begin
                // op 10 and 11 are no-ops
            end
        endcase

        // r15 is never written, a store of r15 still goes out
        if (rd == PC_REG) begin
            reg_write  = 1'b0;
            mem_to_reg = 1'b0;
        end
    end

endmodule

// ==== barrel_shifter.sv ====
`timescale 1ns/1ps

module barrel_shifter import isa_pkg::*; (
    input  word_t  value,
    input  shift_t shift_type,
    input  shamt_t shamt,
    output word_t  result
);

    logic [63:0] doubled;
    logic [63:0] rotated;

    // rotate right as the low half of a doubled word shifted right
    assign doubled = {value, value};
    assign rotated = doubled >> shamt;

    always_comb begin
        case (shift_type)
            SHIFT_LSL: begin
                result = value << shamt;
            end
            SHIFT_LSR: begin
                result = value >> shamt;
            end
            SHIFT_ASR: begin
                // sign fill
                result = word_t'($signed(value) >>> shamt);
            end
            SHIFT_ROR: begin
                result = rotated[31:0];
            end
            default: begin
                result = value;
            end
        endcase
    end

    // amount 0 falls out of every case above as value unchanged

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu import isa_pkg::*; import pipe_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t alu_op,
    output word_t   result
);

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_ORR: begin
                result = a | b;
            end
            ALU_EOR: begin
                result = a ^ b;
            end
            ALU_PASS_B: begin
                // mov
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import isa_pkg::*; import pipe_pkg::*; (
    input  reg_idx_t ra1_d,
    input  reg_idx_t ra2_d,
    input  reg_idx_t ra1_e,
    input  reg_idx_t ra2_e,
    input  reg_idx_t wa_e,
    input  logic     mem_to_reg_e,
    input  reg_idx_t wa_m,
    input  logic     reg_write_m,
    input  reg_idx_t wa_w,
    input  logic     reg_write_w,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b,
    output logic     stall
);

    // youngest producer wins
    function automatic fwd_sel_t pick_source(reg_idx_t ra);
        if (reg_write_m && (wa_m == ra))
            return FWD_MEM;
        else if (reg_write_w && (wa_w == ra))
            return FWD_WB;
        else
            return FWD_REG;
    endfunction

    assign fwd_a = pick_source(ra1_e);
    assign fwd_b = pick_source(ra2_e);

    ////////////////////////////////////////
    // load-use

    // load data only exists after memory, so hold decode one cycle
    assign stall = mem_to_reg_e && ((ra1_d == wa_e) || (ra2_d == wa_e));

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import isa_pkg::*; import pipe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  word_t    rd1_d,
    input  word_t    rd2_d,
    input  word_t    ext_imm_d,
    input  reg_idx_t ra1_d,
    input  reg_idx_t ra2_d,
    input  reg_idx_t wa_d,
    input  logic     reg_write_d,
    input  logic     mem_write_d,
    input  logic     mem_to_reg_d,
    input  logic     alu_src_d,
    input  alu_op_t  alu_op_d,
    input  shift_t   shift_type_d,
    input  shamt_t   shamt_d,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  word_t    result_w,
    output reg_idx_t ra1_e,
    output reg_idx_t ra2_e,
    output reg_idx_t wa_e,
    output logic     mem_to_reg_e,
    output word_t    alu_out_m,
    output word_t    write_data_m,
    output reg_idx_t wa_m,
    output logic     reg_write_m,
    output logic     mem_write_m,
    output logic     mem_to_reg_m
);

    logic    reg_write_e;
    logic    mem_write_e;
    logic    alu_src_e;
    alu_op_t alu_op_e;
    shift_t  shift_type_e;
    shamt_t  shamt_e;
    word_t   rd1_e;
    word_t   rd2_e;
    word_t   ext_imm_e;
    word_t   src_a;
    word_t   reg_b;
    word_t   shifted_b;
    word_t   src_b;
    word_t   alu_result;

    ////////////////////////////////////////
    // decode/execute register

    // a flush leaves a bubble with no side effects
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_e  <= 1'b0;
            mem_write_e  <= 1'b0;
            mem_to_reg_e <= 1'b0;
        end else if (flush) begin
            reg_write_e  <= 1'b0;
            mem_write_e  <= 1'b0;
            mem_to_reg_e <= 1'b0;
        end else begin
            reg_write_e  <= reg_write_d;
            mem_write_e  <= mem_write_d;
            mem_to_reg_e <= mem_to_reg_d;
        end
    end

    always_ff @(posedge clk) begin
        rd1_e        <= rd1_d;
        rd2_e        <= rd2_d;
        ext_imm_e    <= ext_imm_d;
        ra1_e        <= ra1_d;
        ra2_e        <= ra2_d;
        wa_e         <= wa_d;
        alu_src_e    <= alu_src_d;
        alu_op_e     <= alu_op_d;
        shift_type_e <= shift_type_d;
        shamt_e      <= shamt_d;
    end

    ////////////////////////////////////////
    // operands

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val);
        case (sel)
            FWD_MEM: return alu_out_m;
            FWD_WB:  return result_w;
            default: return reg_val;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_a, rd1_e);
    assign reg_b = fwd_mux(fwd_b, rd2_e);

    barrel_shifter u_shifter (
        .value      (reg_b),
        .shift_type (shift_type_e),
        .shamt      (shamt_e),
        .result     (shifted_b)
    );

    assign src_b = alu_src_e ? ext_imm_e : shifted_b;

    alu u_alu (
        .a      (src_a),
        .b      (src_b),
        .alu_op (alu_op_e),
        .result (alu_result)
    );

    ////////////////////////////////////////
    // execute/memory register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_m  <= 1'b0;
            mem_write_m  <= 1'b0;
            mem_to_reg_m <= 1'b0;
        end else begin
            reg_write_m  <= reg_write_e;
            mem_write_m  <= mem_write_e;
            mem_to_reg_m <= mem_to_reg_e;
        end
    end

    // store data is the unshifted rd value
    always_ff @(posedge clk) begin
        alu_out_m    <= alu_result;
        write_data_m <= reg_b;
        wa_m         <= wa_e;
    end

endmodule

// ==== arm_pipeline.sv ====
`timescale 1ns/1ps

module arm_pipeline import isa_pkg::*; import pipe_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  word_t instr,
    input  word_t read_data,
    output word_t pc,
    output word_t addr_data,
    output word_t write_data,
    output logic  mem_write
);

    word_t    instr_d;
    word_t    r15;
    logic     stall;

    reg_idx_t ra1_d;
    reg_idx_t ra2_d;
    reg_idx_t wa_d;
    logic     reg_write_d;
    logic     mem_write_d;
    logic     mem_to_reg_d;
    logic     alu_src_d;
    alu_op_t  alu_op_d;
    word_t    ext_imm_d;
    shift_t   shift_type_d;
    shamt_t   shamt_d;
    word_t    rd1_d;
    word_t    rd2_d;

    reg_idx_t ra1_e;
    reg_idx_t ra2_e;
    reg_idx_t wa_e;
    logic     mem_to_reg_e;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    word_t    alu_out_m;
    word_t    write_data_m;
    reg_idx_t wa_m;
    logic     reg_write_m;
    logic     mem_write_m;
    logic     mem_to_reg_m;

    word_t    alu_out_w;
    word_t    read_data_w;
    reg_idx_t wa_w;
    logic     reg_write_w;
    logic     mem_to_reg_w;
    word_t    result_w;

    ////////////////////////////////////////
    // fetch

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= RESET_PC;
            instr_d <= '0;
        end else if (!stall) begin
            pc      <= pc + PC_STEP;
            instr_d <= instr;
        end
    end

    // pc is one step ahead of decode, so this is the decode address plus 8
    assign r15 = pc + PC_STEP;

    ////////////////////////////////////////
    // decode

    instr_decoder u_decoder (
        .instr      (instr_d),
        .ra1        (ra1_d),
        .ra2        (ra2_d),
        .wa         (wa_d),
        .reg_write  (reg_write_d),
        .mem_write  (mem_write_d),
        .mem_to_reg (mem_to_reg_d),
        .alu_src    (alu_src_d),
        .alu_op     (alu_op_d),
        .ext_imm    (ext_imm_d),
        .shift_type (shift_type_d),
        .shamt      (shamt_d)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .reset (reset),
        .ra1   (ra1_d),
        .ra2   (ra2_d),
        .wa    (wa_w),
        .we    (reg_write_w),
        .wd    (result_w),
        .r15   (r15),
        .rd1   (rd1_d),
        .rd2   (rd2_d)
    );

    hazard_unit u_hazard (
        .ra1_d        (ra1_d),
        .ra2_d        (ra2_d),
        .ra1_e        (ra1_e),
        .ra2_e        (ra2_e),
        .wa_e         (wa_e),
        .mem_to_reg_e (mem_to_reg_e),
        .wa_m         (wa_m),
        .reg_write_m  (reg_write_m),
        .wa_w         (wa_w),
        .reg_write_w  (reg_write_w),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .stall        (stall)
    );

    ////////////////////////////////////////
    // execute

    execute_stage u_execute (
        .clk          (clk),
        .reset        (reset),
        .flush        (stall),
        .rd1_d        (rd1_d),
        .rd2_d        (rd2_d),
        .ext_imm_d    (ext_imm_d),
        .ra1_d        (ra1_d),
        .ra2_d        (ra2_d),
        .wa_d         (wa_d),
        .reg_write_d  (reg_write_d),
        .mem_write_d  (mem_write_d),
        .mem_to_reg_d (mem_to_reg_d),
        .alu_src_d    (alu_src_d),
        .alu_op_d     (alu_op_d),
        .shift_type_d (shift_type_d),
        .shamt_d      (shamt_d),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .result_w     (result_w),
        .ra1_e        (ra1_e),
        .ra2_e        (ra2_e),
        .wa_e         (wa_e),
        .mem_to_reg_e (mem_to_reg_e),
        .alu_out_m    (alu_out_m),
        .write_data_m (write_data_m),
        .wa_m         (wa_m),
        .reg_write_m  (reg_write_m),
        .mem_write_m  (mem_write_m),
        .mem_to_reg_m (mem_to_reg_m)
    );

    ////////////////////////////////////////
    // memory

    assign addr_data  = alu_out_m;
    assign write_data = write_data_m;
    assign mem_write  = mem_write_m;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_w  <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else begin
            reg_write_w  <= reg_write_m;
            mem_to_reg_w <= mem_to_reg_m;
        end
    end

    always_ff @(posedge clk) begin
        alu_out_w   <= alu_out_m;
        read_data_w <= read_data;
        wa_w        <= wa_m;
    end

    ////////////////////////////////////////
    // writeback

    assign result_w = mem_to_reg_w ? read_data_w : alu_out_w;

endmodule

// ==== tb_arm_pipeline.sv ====
`timescale 1ns/1ps

module tb_arm_pipeline import isa_pkg::*; import pipe_pkg::*; ();

    localparam int    PROG_LEN      = 300;
    localparam int    TOTAL_LEN     = PROG_LEN + NUM_GP_REGS;
    localparam int    CLK_PERIOD    = 8;
    localparam int    DRIVE_DELAY   = 1;
    localparam int    RESET_CYCLES  = 10;
    localparam int    SETTLE_CYCLES = 8;
    localparam word_t NOP_WORD      = 32'h0800_0000;
    localparam word_t FILL_KEY      = 32'h3c5a_96e1;

    logic  clk;
    logic  reset;
    word_t instr;
    word_t read_data;
    word_t pc;
    word_t addr_data;
    word_t write_data;
    logic  mem_write;

    word_t prog [TOTAL_LEN];
    word_t dmem [word_t];
    word_t model_mem [word_t];
    word_t model_regs [NUM_GP_REGS];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    exp_total;
    int    exp_stalls;
    int    stores_seen;
    int    pc_repeats;

    arm_pipeline u_dut (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (pc),
        .addr_data  (addr_data),
        .write_data (write_data),
        .mem_write  (mem_write)
    );

    ////////////////////////////////////////
    // error reporting

    task automatic stop_with(string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic value_error(string msg);
        stop_with($sformatf("FAILED at %0d ns: %s", $time, msg));
    endtask

    ////////////////////////////////////////
    // memories

    // unwritten words mix in their own address
    function automatic word_t fill_word(word_t a);
        return a ^ FILL_KEY;
    endfunction

    function automatic word_t fetch_word(word_t a);
        if ($isunknown(a) || (a >> 2) >= TOTAL_LEN)
            return NOP_WORD;
        return prog[a >> 2];
    endfunction

    function automatic word_t dmem_read(word_t a);
        if ($isunknown(a))
            return '0;
        return dmem.exists(a) ? dmem[a] : fill_word(a);
    endfunction

    ////////////////////////////////////////
    // program generation

    // mostly r0 to r7 so results get reused
    function automatic reg_idx_t pick_reg();
        return ($urandom % 4 != 0) ? reg_idx_t'($urandom % 8) : reg_idx_t'($urandom % 16);
    endfunction

    function automatic logic [3:0] pick_cmd();
        case ($urandom % 6)
            0: return CMD_AND;
            1: return CMD_EOR;
            2: return CMD_SUB;
            3: return CMD_ADD;
            4: return CMD_ORR;
            default: return CMD_MOV;
        endcase
    endfunction

    function automatic word_t enc_data(logic [3:0] cmd, reg_idx_t rn, reg_idx_t rd);
        word_t w;
        w = 32'he000_0000;
        w[OP_MSB:OP_LSB] = OP_DATA;
        w[CMD_MSB:CMD_LSB] = cmd;
        // s bit sits where L does, random since flags are gone
        w[LOAD_BIT] = 1'($urandom);
        w[RN_LSB +: 4] = rn;
        w[RD_LSB +: 4] = rd;
        if ($urandom % 3 == 0) begin
            w[IMM_BIT] = 1'b1;
            w[IMM8_W-1:0] = 8'($urandom);
        end else begin
            w[RM_LSB +: 4] = pick_reg();
            w[SH_LSB +: 2] = 2'($urandom);
            w[SHAMT_LSB +: 5] = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
        end
        return w;
    endfunction

    function automatic word_t enc_mem(logic load, logic up, reg_idx_t rn, reg_idx_t rd,
                                      logic [IMM12_W-1:0] off);
        word_t w;
        w = 32'he000_0000;
        w[OP_MSB:OP_LSB] = OP_MEM;
        w[UP_BIT] = up;
        w[LOAD_BIT] = load;
        w[RN_LSB +: 4] = rn;
        w[RD_LSB +: 4] = rd;
        w[IMM12_W-1:0] = off;
        return w;
    endfunction

    task automatic gen_program();
        int unsigned kind;
        word_t       w;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = $urandom % 100;
            if (kind < 45) begin
                w = enc_data(pick_cmd(), pick_reg(), pick_reg());
            end else if (kind < 72) begin
                w = enc_mem(1'b1, 1'($urandom), pick_reg(), pick_reg(), 12'($urandom % 16) << 2);
            end else if (kind < 86) begin
                w = enc_mem(1'b0, 1'($urandom), pick_reg(), pick_reg(), 12'($urandom % 16) << 2);
            end else if (kind < 91) begin
                w = enc_data(pick_cmd(), pick_reg(), PC_REG);
            end else if (kind < 95) begin
                // unimplemented command
                w = enc_data(4'b1010, pick_reg(), pick_reg());
            end else begin
                w = $urandom;
                w[OP_MSB] = 1'b1;
            end
            prog[i] = w;
        end
        // register dump, addressed off r15
        for (int r = 0; r < NUM_GP_REGS; r++)
            prog[PROG_LEN + r] = enc_mem(1'b0, 1'b1, PC_REG, reg_idx_t'(r), 12'h400);
    endtask

    ////////////////////////////////////////
    // reference model

    function automatic word_t shift_model(word_t v, logic [1:0] kind, logic [4:0] n);
        word_t fill;
        fill = (v[31] && n != 0) ? ~(32'hffff_ffff >> n) : '0;
        if (n == 0)
            return v;
        case (kind)
            SHIFT_LSL: return v << n;
            SHIFT_LSR: return v >> n;
            SHIFT_ASR: return (v >> n) | fill;
            default:   return (v >> n) | (v << (32 - n));
        endcase
    endfunction

    function automatic word_t model_read(reg_idx_t r, word_t own_addr);
        if (r == PC_REG)
            return own_addr + PC_R15_OFFSET;
        return model_regs[r];
    endfunction

    // decode source indices, both count even when unused
    function automatic logic reads_reg(word_t w, reg_idx_t r);
        reg_idx_t src2;
        src2 = (w[OP_MSB:OP_LSB] == OP_MEM && !w[LOAD_BIT]) ? w[RD_LSB +: 4] : w[RM_LSB +: 4];
        return (w[RN_LSB +: 4] == r) || (src2 == r);
    endfunction

    task automatic run_model();
        word_t      w;
        word_t      own_addr;
        word_t      a;
        word_t      b;
        word_t      res;
        logic       valid;
        reg_idx_t   rd;
        for (int r = 0; r < NUM_GP_REGS; r++)
            model_regs[r] = '0;
        exp_stalls = 0;
        for (int i = 0; i < TOTAL_LEN; i++) begin
            w = prog[i];
            own_addr = RESET_PC + i * PC_STEP;
            rd = w[RD_LSB +: 4];
            a = model_read(w[RN_LSB +: 4], own_addr);
            if (w[OP_MSB:OP_LSB] == OP_DATA) begin
                if (w[IMM_BIT])
                    b = {24'b0, w[7:0]};
                else
                    b = shift_model(model_read(w[RM_LSB +: 4], own_addr),
                                    w[SH_LSB +: 2], w[SHAMT_LSB +: 5]);
                valid = 1'b1;
                case (w[CMD_MSB:CMD_LSB])
                    CMD_AND: res = a & b;
                    CMD_EOR: res = a ^ b;
                    CMD_SUB: res = a - b;
                    CMD_ADD: res = a + b;
                    CMD_ORR: res = a | b;
                    CMD_MOV: res = b;
                    default: valid = 1'b0;
                endcase
                if (valid && rd != PC_REG)
                    model_regs[rd] = res;
            end else if (w[OP_MSB:OP_LSB] == OP_MEM) begin
                res = w[UP_BIT] ? a + w[11:0] : a - w[11:0];
                if (w[LOAD_BIT]) begin
                    if (rd != PC_REG)
                        model_regs[rd] = model_mem.exists(res) ? model_mem[res] : fill_word(res);
                    // load-use costs one cycle
                    if (rd != PC_REG && reads_reg(fetch_word(own_addr + PC_STEP), rd))
                        exp_stalls++;
                end else begin
                    exp_addr.push_back(res);
                    exp_data.push_back(model_read(rd, own_addr));
                    model_mem[res] = model_read(rd, own_addr);
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // clock, stimulus, monitor

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memories answer for the pc and address of this cycle
    initial begin
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            instr = fetch_word(pc);
            read_data = dmem_read(addr_data);
        end
    end

    task automatic check_store();
        assert (exp_addr.size() > 0)
            else value_error($sformatf("unexpected store to %h", addr_data));
        assert (addr_data === exp_addr[0] && write_data === exp_data[0])
            else value_error($sformatf("store %0d: got %h <- %h, expected %h <- %h",
                             stores_seen, addr_data, write_data, exp_addr[0], exp_data[0]));
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        dmem[addr_data] = write_data;
        stores_seen++;
    endtask

    initial begin
        logic  tracking;
        word_t last_pc;
        tracking = 1'b0;
        forever begin
            @(negedge clk);
            if (reset || !tracking) begin
                assert (mem_write === 1'b0 && pc === RESET_PC)
                    else value_error($sformatf("around reset pc=%h mem_write=%b", pc, mem_write));
                tracking = !reset;
            end else if (pc === last_pc) begin
                pc_repeats++;
            end else begin
                assert (pc === last_pc + PC_STEP)
                    else value_error($sformatf("pc went from %h to %h", last_pc, pc));
            end
            last_pc = pc;
            assert (!$isunknown(mem_write))
                else value_error("mem_write is unknown");
            if (mem_write === 1'b1)
                check_store();
        end
    end

    initial begin
        #((RESET_CYCLES + 4 * TOTAL_LEN) * CLK_PERIOD);
        stop_with($sformatf("timeout: the stores did not complete, %0d of %0d seen",
                            stores_seen, exp_total));
    end

    ////////////////////////////////////////
    // main sequence

    initial begin
        int unsigned seed;
        seed = 32'hadfb_ae14;
        reset = 1'b1;
        instr = '0;
        read_data = '0;
        stores_seen = 0;
        pc_repeats = 0;
        void'($urandom(seed));
        gen_program();
        run_model();
        exp_total = exp_addr.size();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        wait (stores_seen == exp_total);
        // catch stray strobes after the dump
        repeat (SETTLE_CYCLES) @(negedge clk);
        assert (pc_repeats == exp_stalls)
            else value_error($sformatf("%0d repeated pc values, expected %0d load-use stalls",
                             pc_repeats, exp_stalls));
        $display("Test OK");
        $finish;
    end

endmodule

// ==== all.f ====
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
instr_decoder.sv
barrel_shifter.sv
alu.sv
hazard_unit.sv
execute_stage.sv
arm_pipeline.sv
tb_arm_pipeline.sv
